//--- verilog.f
design/afifo_cfg_pkg.sv
design/afifo_gray_pkg.sv
design/afifo_mem.sv
design/afifo_gray_sync.sv
design/afifo_wr_ptr.sv
design/afifo_rd_ptr.sv
design/afifo_top.sv
tests/afifo_clk_gen.sv
tests/afifo_tb.sv

//--- tests/afifo_tb.sv
`timescale 1ns/1ns

module afifo_tb;

	import afifo_cfg_pkg::*;

	localparam int DEPTH = 1 << DEF_LGFIFO;
	// Memory slots plus the word parked in the output register
	localparam int CAPACITY = DEPTH + 1;
	localparam int RESET_CYCLES = 4;
	localparam int FILL_CYCLES = 40;
	localparam int MIX_CYCLES = 400;
	localparam int SETTLE_CYCLES = 8;
	localparam int DRAIN_CYCLES = 40;
	localparam int STIM_CYCLES = RESET_CYCLES + FILL_CYCLES + 2 * MIX_CYCLES
		+ SETTLE_CYCLES + DRAIN_CYCLES;
	localparam int WATCHDOG_NS = 40 * STIM_CYCLES * 20;

	logic gbl_clk;
	logic i_wr_clk;
	logic i_rd_reset_n;
	logic i_wr_reset_n;
	logic i_wr;
	logic [DEF_WIDTH-1:0] i_wr_data;
	logic o_wr_full;
	logic i_rd;
	logic [DEF_WIDTH-1:0] o_rd_data;
	logic o_rd_empty;

	integer seed;
	int mismatch_count;
	int other_count;
	// Reference model of accepted, not yet consumed words
	logic [DEF_WIDTH-1:0] model_q[$];
	int q_count;
	logic [DEF_WIDTH-1:0] head_word;
	logic [DEF_WIDTH-1:0] prev_rd_data;
	// Phase control
	logic wr_stop;
	logic draining;

	afifo_clk_gen #(
		.RD_PERIOD(20),
		.WR_PERIOD(14),
		.RESET_CYCLES(RESET_CYCLES)
	) clk_gen_i (
		.o_gbl_clk(gbl_clk),
		.o_wr_clk(i_wr_clk),
		.o_rd_reset_n(i_rd_reset_n),
		.o_wr_reset_n(i_wr_reset_n)
	);

	afifo_top afifo_top_i (
		.i_wr_clk(i_wr_clk),
		.i_wr_reset_n(i_wr_reset_n),
		.i_wr(i_wr),
		.i_wr_data(i_wr_data),
		.o_wr_full(o_wr_full),
		.gbl_clk(gbl_clk),
		.i_rd_reset_n(i_rd_reset_n),
		.i_rd(i_rd),
		.o_rd_data(o_rd_data),
		.o_rd_empty(o_rd_empty)
	);

	////////////////////
	// Reference model
	////////////////////

	task automatic refresh_model_view();
		q_count = model_q.size();
		if (q_count > 0)
			head_word = model_q[0];
	endtask

	// Write rule seen from outside, old values at the edge
	always @(posedge i_wr_clk)
	begin
		if (i_wr_reset_n && i_wr && !o_wr_full)
		begin
			model_q.push_back(i_wr_data);
			refresh_model_view();
		end
	end

	// Read rule, pop the word the consumer takes
	always @(posedge gbl_clk)
	begin
		prev_rd_data <= o_rd_data;
		if (i_rd_reset_n && i_rd && !o_rd_empty && model_q.size() > 0)
		begin
			void'(model_q.pop_front());
			refresh_model_view();
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Flags while in reset and on the first edge out of it
	a_reset_flags: assert property (@(posedge gbl_clk)
		!i_rd_reset_n |=> (o_rd_empty && !o_wr_full))
		else
		begin
			mismatch_count++;
			$display("MISMATCH test=reset_flags expected empty=1 full=0 actual empty=%b full=%b",
				$sampled(o_rd_empty), $sampled(o_wr_full));
		end

	a_read_backed: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		(i_rd && !o_rd_empty) |-> (q_count != 0))
		else
		begin
			other_count++;
			$display("read taken while the reference queue holds no word");
		end

	// Oldest accepted word comes out first
	a_data_order: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		(i_rd && !o_rd_empty && q_count != 0) |-> (o_rd_data == head_word))
		else
		begin
			mismatch_count++;
			$display("MISMATCH test=data_order expected=%h actual=%h",
				$sampled(head_word), $sampled(o_rd_data));
		end

	a_no_overflow: assert property (@(posedge i_wr_clk) disable iff (!i_wr_reset_n)
		q_count <= CAPACITY)
		else
		begin
			other_count++;
			$display("FIFO accepted %0d words, more than its capacity of %0d",
				$sampled(q_count), CAPACITY);
		end

	// At capacity only a consumer read can clear full
	a_full_at_cap: assert property (@(posedge i_wr_clk) disable iff (!i_wr_reset_n)
		(q_count == CAPACITY) |-> o_wr_full)
		else
		begin
			other_count++;
			$display("full flag low while the FIFO holds %0d words", CAPACITY);
		end

	a_hold: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		(!o_rd_empty && !i_rd) |=> (o_rd_data == prev_rd_data && !o_rd_empty))
		else
		begin
			mismatch_count++;
			$display("MISMATCH test=hold expected=%h actual=%h",
				$sampled(prev_rd_data), $sampled(o_rd_data));
		end

	a_drain_empty: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		(draining && o_rd_empty) |-> (q_count == 0))
		else
		begin
			other_count++;
			$display("empty flag high with %0d words still queued", $sampled(q_count));
		end

	////////////////////
	// Stimulus
	////////////////////

	task automatic fill_fifo(input int n);
		repeat (n)
		begin
			@(posedge i_wr_clk);
			i_wr <= 1'b1;
			i_wr_data <= DEF_WIDTH'($random(seed));
		end
		@(posedge i_wr_clk);
		i_wr <= 1'b0;
	endtask

	// Random writes until the read side ends the phase
	task automatic drive_writes(input int pct);
		int r;
		while (!wr_stop)
		begin
			@(posedge i_wr_clk);
			r = $unsigned($random(seed)) % 100;
			i_wr <= (r < pct);
			i_wr_data <= DEF_WIDTH'($random(seed));
		end
		@(posedge i_wr_clk);
		i_wr <= 1'b0;
	endtask

	task automatic drive_reads(input int n, input int pct);
		int r;
		repeat (n)
		begin
			@(posedge gbl_clk);
			r = $unsigned($random(seed)) % 100;
			i_rd <= (r < pct);
		end
		@(posedge gbl_clk);
		i_rd <= 1'b0;
	endtask

	task automatic mix_phase(input int wr_pct, input int rd_pct, input int n);
		wr_stop = 1'b0;
		fork
			begin
				drive_reads(n, rd_pct);
				wr_stop = 1'b1;
			end
			drive_writes(wr_pct);
		join
	endtask

	// Writes are off, let the last pointer cross, then read until empty
	task automatic drain_fifo();
		repeat (SETTLE_CYCLES) @(posedge gbl_clk);
		draining <= 1'b1;
		i_rd <= 1'b1;
		do
			@(posedge gbl_clk);
		while (!o_rd_empty);
		i_rd <= 1'b0;
		repeat (2) @(posedge gbl_clk);
	endtask

	initial
	begin
		seed = 32'h3615_9bc0;
		i_wr = 1'b0;
		i_wr_data = '0;
		i_rd = 1'b0;
		wr_stop = 1'b0;
		draining = 1'b0;
		mismatch_count = 0;
		other_count = 0;
		q_count = 0;
		head_word = '0;
		@(posedge i_rd_reset_n);
		// Reads held off, run into full
		fill_fifo(FILL_CYCLES);
		// Producer ahead, then consumer ahead
		mix_phase(70, 40, MIX_CYCLES);
		mix_phase(30, 80, MIX_CYCLES);
		drain_fifo();
		$display("report: %0d mismatches, %0d other errors, %0d words left",
			mismatch_count, other_count, model_q.size());
		if (mismatch_count + other_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("run did not finish within %0d ns, FIFO never drained", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

endmodule

//--- tests/afifo_clk_gen.sv
`timescale 1ns/1ns

module afifo_clk_gen #(
	parameter int RD_PERIOD = 20,
	parameter int WR_PERIOD = 14,
	parameter int RESET_CYCLES = 4
) (
	output logic o_gbl_clk,
	output logic o_wr_clk,
	output logic o_rd_reset_n,
	output logic o_wr_reset_n
);

	// Consumer clock
	initial
	begin
		o_gbl_clk = 1'b0;
		forever #(RD_PERIOD / 2) o_gbl_clk = ~o_gbl_clk;
	end

	// Producer clock, unrelated to gbl_clk
	initial
	begin
		o_wr_clk = 1'b0;
		forever #(WR_PERIOD / 2) o_wr_clk = ~o_wr_clk;
	end

	// Both resets held for a few consumer cycles
	initial
	begin
		o_rd_reset_n = 1'b0;
		o_wr_reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_gbl_clk);
		o_rd_reset_n <= 1'b1;
		o_wr_reset_n <= 1'b1;
	end

endmodule

//--- design/afifo_top.sv
`timescale 1ns/1ns

module afifo_top #(
	parameter int LGFIFO = afifo_cfg_pkg::DEF_LGFIFO,
	parameter int WIDTH = afifo_cfg_pkg::DEF_WIDTH,
	parameter int NFF = afifo_cfg_pkg::DEF_NFF
) (
	// Producer side
	input logic i_wr_clk,
	input logic i_wr_reset_n,
	input logic i_wr,
	input logic [WIDTH-1:0] i_wr_data,
	output logic o_wr_full,
	// Consumer side
	input logic gbl_clk,
	input logic i_rd_reset_n,
	input logic i_rd,
	output logic [WIDTH-1:0] o_rd_data,
	output logic o_rd_empty
);

	// Write domain nets
	logic wr_en;
	logic [LGFIFO-1:0] wr_addr;
	logic [LGFIFO:0] wgray;
	logic [LGFIFO:0] wr_rgray;

	// Read domain nets
	logic [LGFIFO-1:0] rd_addr;
	logic [LGFIFO:0] rgray;
	logic [LGFIFO:0] rd_wgray;
	logic [WIDTH-1:0] mem_rd_data;

	////////////////////
	// Write domain
	////////////////////

	afifo_wr_ptr #(
		.LGFIFO(LGFIFO)
	) wr_ptr_i (
		.i_wr_clk(i_wr_clk),
		.i_wr_reset_n(i_wr_reset_n),
		.i_wr(i_wr),
		.i_wr_rgray(wr_rgray),
		.o_wr_full(o_wr_full),
		.o_wr_en(wr_en),
		.o_wr_addr(wr_addr),
		.o_wgray(wgray)
	);

	// Read pointer arriving on the write clock
	afifo_gray_sync #(
		.LGFIFO(LGFIFO),
		.NFF(NFF)
	) rd_to_wr_sync (
		.i_clk(i_wr_clk),
		.i_reset_n(i_wr_reset_n),
		.i_gray(rgray),
		.o_gray(wr_rgray)
	);

	// Shared storage, written here and read from the other side
	afifo_mem #(
		.LGFIFO(LGFIFO),
		.WIDTH(WIDTH)
	) mem_i (
		.i_wr_clk(i_wr_clk),
		.i_wr_en(wr_en),
		.i_wr_addr(wr_addr),
		.i_wr_data(i_wr_data),
		.i_rd_addr(rd_addr),
		.o_rd_data(mem_rd_data)
	);

	////////////////////
	// Read domain
	////////////////////

	// Write pointer arriving on gbl_clk
	afifo_gray_sync #(
		.LGFIFO(LGFIFO),
		.NFF(NFF)
	) wr_to_rd_sync (
		.i_clk(gbl_clk),
		.i_reset_n(i_rd_reset_n),
		.i_gray(wgray),
		.o_gray(rd_wgray)
	);

	afifo_rd_ptr #(
		.LGFIFO(LGFIFO),
		.WIDTH(WIDTH)
	) rd_ptr_i (
		.gbl_clk(gbl_clk),
		.i_rd_reset_n(i_rd_reset_n),
		.i_rd(i_rd),
		.i_rd_wgray(rd_wgray),
		.i_mem_data(mem_rd_data),
		.o_rd_addr(rd_addr),
		.o_rgray(rgray),
		.o_rd_data(o_rd_data),
		.o_rd_empty(o_rd_empty)
	);

endmodule

//--- design/afifo_rd_ptr.sv
`timescale 1ns/1ns

module afifo_rd_ptr #(
	parameter int LGFIFO = 3,
	parameter int WIDTH = 16
) (
	input logic gbl_clk,
	input logic i_rd_reset_n,
	// Consumer takes the presented word
	input logic i_rd,
	// Write pointer after the crossing
	input logic [LGFIFO:0] i_rd_wgray,
	// Word at the current read address
	input logic [WIDTH-1:0] i_mem_data,
	output logic [LGFIFO-1:0] o_rd_addr,
	// Gray copy, sent across to the write side
	output logic [LGFIFO:0] o_rgray,
	// Registered output stage
	output logic [WIDTH-1:0] o_rd_data,
	output logic o_rd_empty
);

	import afifo_gray_pkg::*;

	// Binary read count, lap bit on top
	logic [LGFIFO:0] rbin;
	logic [LGFIFO:0] rbin_next;
	// Memory side empty, before the output register
	logic empty_int;
	// Output stage wants a new word
	logic load;

	////////////////////
	// Internal empty
	////////////////////

	// Same Gray value on both sides means nothing stored
	assign empty_int = (o_rgray == i_rd_wgray);

	// Refill when the stage is vacant or its word is being taken
	assign load = o_rd_empty || i_rd;

	////////////////////
	// Pointer update
	////////////////////

	assign rbin_next = rbin + (LGFIFO+1)'(1);

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			rbin <= '0;
			o_rgray <= '0;
		end
		else if (load && !empty_int)
		begin
			rbin <= rbin_next;
			o_rgray <= (LGFIFO+1)'(bin_to_gray(GRAY_W'(rbin_next)));
		end
	end

	assign o_rd_addr = rbin[LGFIFO-1:0];

	////////////////////
	// Output stage
	////////////////////

	// Empty follows the memory only when the stage moves
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
			o_rd_empty <= 1'b1;
		else if (load)
			o_rd_empty <= empty_int;
	end

	// Data word, meaningful only while o_rd_empty is low
	always_ff @(posedge gbl_clk)
	begin
		if (load)
			o_rd_data <= i_mem_data;
	end

	// A held word stays put and stays valid until the consumer reads it
	a_hold: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		!o_rd_empty && !i_rd |=> $stable(o_rd_data) && !o_rd_empty)
		else $error("output word changed under back-pressure");

endmodule

//--- design/afifo_wr_ptr.sv
`timescale 1ns/1ns

module afifo_wr_ptr #(
	parameter int LGFIFO = 3
) (
	input logic i_wr_clk,
	input logic i_wr_reset_n,
	// Producer request
	input logic i_wr,
	// Read pointer after the crossing
	input logic [LGFIFO:0] i_wr_rgray,
	output logic o_wr_full,
	// Memory write port control
	output logic o_wr_en,
	output logic [LGFIFO-1:0] o_wr_addr,
	// Gray copy, sent across to the read side
	output logic [LGFIFO:0] o_wgray
);

	import afifo_gray_pkg::*;

	// Binary write count, one extra bit for the lap
	logic [LGFIFO:0] wbin;
	logic [LGFIFO:0] wbin_next;

	////////////////////
	// Pointer update
	////////////////////

	assign wbin_next = wbin + (LGFIFO+1)'(1);

	// Accept only when there is room
	assign o_wr_en = i_wr && !o_wr_full;

	always_ff @(posedge i_wr_clk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
		begin
			wbin <= '0;
			o_wgray <= '0;
		end
		else if (o_wr_en)
		begin
			wbin <= wbin_next;
			// Gray taken from the next count so both move together
			o_wgray <= (LGFIFO+1)'(bin_to_gray(GRAY_W'(wbin_next)));
		end
	end

	// Slot index drops the lap bit
	assign o_wr_addr = wbin[LGFIFO-1:0];

	////////////////////
	// Full flag
	////////////////////

	// The crossed read pointer lags, so full may linger a few edges
	assign o_wr_full = gray_is_full(GRAY_W'(o_wgray), GRAY_W'(i_wr_rgray), LGFIFO);

	// A full FIFO must not advance on the next edge
	a_no_move_full: assert property (@(posedge i_wr_clk) disable iff (!i_wr_reset_n)
		o_wr_full |=> $stable(wbin))
		else $error("write pointer moved while full");

	// The synchronizer relies on one bit changing per edge
	a_gray_step: assert property (@(posedge i_wr_clk) disable iff (!i_wr_reset_n)
		$onehot0(o_wgray ^ $past(o_wgray)))
		else $error("write Gray pointer changed in more than one bit");

endmodule

//--- design/afifo_gray_sync.sv
`timescale 1ns/1ns

module afifo_gray_sync #(
	parameter int LGFIFO = 3,
	parameter int NFF = 2
) (
	// Clock and reset of the receiving domain
	input logic i_clk,
	input logic i_reset_n,
	// Gray pointer from the far domain
	input logic [LGFIFO:0] i_gray,
	// Same pointer, settled in this domain
	output logic [LGFIFO:0] o_gray
);

	// Fewer than two stages leaves no settling time
	if (NFF < 2)
		$error("afifo_gray_sync needs NFF of at least 2");

	////////////////////
	// Flop chain
	////////////////////

	// Stage 0 is the capture flop, stage NFF-1 feeds the logic
	logic [NFF-1:0][LGFIFO:0] chain;

	always_ff @(posedge i_clk or negedge i_reset_n)
	begin
		if (!i_reset_n)
			chain <= '0;
		else
			// Shift toward the top, new sample enters at the bottom
			chain <= {chain[NFF-2:0], i_gray};
	end

	// Only one bit moves at a time, so any sample is a real pointer
	assign o_gray = chain[NFF-1];

endmodule

//--- design/afifo_mem.sv
`timescale 1ns/1ns

module afifo_mem #(
	parameter int LGFIFO = 3,
	parameter int WIDTH = 16
) (
	// Write port, owned by the producer clock
	input logic i_wr_clk,
	input logic i_wr_en,
	input logic [LGFIFO-1:0] i_wr_addr,
	input logic [WIDTH-1:0] i_wr_data,
	// Read port, no clock
	input logic [LGFIFO-1:0] i_rd_addr,
	output logic [WIDTH-1:0] o_rd_data
);

	////////////////////
	// Storage
	////////////////////

	// One word per slot, 2^LGFIFO slots
	logic [WIDTH-1:0] mem [1<<LGFIFO];

	// Write side
	// Enable already excludes writes while full
	always_ff @(posedge i_wr_clk)
	begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// Read side
	// Straight from the array, the output register lives in the read pointer block
	assign o_rd_data = mem[i_rd_addr];

endmodule

//--- design/afifo_gray_pkg.sv
package afifo_gray_pkg;

	////////////////////
	// Pointer arithmetic
	////////////////////

	// Working width for the pointer helpers
	// Callers zero-extend into it and truncate the result back
	localparam int GRAY_W = 32;

	// Binary count to reflected Gray code
	function automatic logic [GRAY_W-1:0] bin_to_gray(input logic [GRAY_W-1:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	// Full when the far pointer sits one lap behind
	// In Gray code that is the near pointer with its two top bits flipped
	function automatic logic gray_is_full(
		input logic [GRAY_W-1:0] wgray,
		input logic [GRAY_W-1:0] rgray,
		input int msb
	);
		logic [GRAY_W-1:0] mask;
		// Two ones lined up under the top pair of pointer bits
		mask = GRAY_W'(2'b11) << (msb - 1);
		return rgray == (wgray ^ mask);
	endfunction

endpackage

//--- design/afifo_cfg_pkg.sv
package afifo_cfg_pkg;

	////////////////////
	// Default FIFO geometry
	////////////////////

	// Log2 of the number of entries
	parameter int DEF_LGFIFO = 3;

	// Bits per stored word
	parameter int DEF_WIDTH = 16;

	// Flops per clock crossing
	// Two is the least that gives a usable settling window
	parameter int DEF_NFF = 2;

endpackage
